//--- bench/fan_cases.txt
# name button gesture fan led timer; gesture S single, D double, L long, T timer tap, E expiry
# timer column: 0 off, 1 one minute, 2 three minutes, 3 five minutes
tmr_idle        2 T 0 0 0
led_1           1 S 0 1 0
led_2           1 S 0 2 0
led_3           1 S 0 3 0
led_wrap        1 S 0 0 0
led_again       1 S 0 1 0
led_dbl_ignored 1 D 0 1 0
led_long_clear  1 L 0 0 0
fan_up_1        0 S 1 0 0
fan_up_2        0 S 2 0 0
fan_up_3        0 S 3 0 0
fan_up_4        0 S 4 0 0
fan_up_5        0 S 5 0 0
fan_up_6        0 S 6 0 0
fan_up_7        0 S 7 0 0
fan_wrap_up     0 S 0 0 0
fan_wrap_down   0 D 7 0 0
fan_down_6      0 D 6 0 0
tmr_1           2 T 6 0 1
tmr_3           2 T 6 0 2
tmr_5           2 T 6 0 3
tmr_off         2 T 6 0 0
tmr_arm         2 T 6 0 1
tmr_stop_fan    0 L 0 0 0
fan_on          0 S 1 0 0
tmr_arm_2       2 T 1 0 1
tmr_expire      2 E 0 0 0

//--- bench/fan_tb.sv
`timescale 1ns/1ns

module fan_tb import button_pkg::*, fan_pkg::*; ();

    localparam int TICK_DIV = 2;
    localparam int CLK_NS   = 8;

    logic       clk;
    logic       reset_p;
    logic [2:0] btn;
    logic       fan_pwm;
    logic       led_pwm;
    fan_level_t fan_level;
    led_level_t led_level;
    timer_sel_t timer_sel;
    secs_t      remaining_s;

    string  case_name [$];
    string  case_code [$];
    int     case_btn [$];
    int     exp_fan [$];
    int     exp_led [$];
    int     exp_tmr [$];
    int     seed = 32'h957f;
    int     fail_count = 0;
    int     case_errs = 0;
    longint limit_ns = 0;

    fan_top #(
        .TICK_DIV (TICK_DIV)
    ) dut_i (
        .clk         (clk),
        .reset_p     (reset_p),
        .btn         (btn),
        .fan_pwm     (fan_pwm),
        .led_pwm     (led_pwm),
        .fan_level   (fan_level),
        .led_level   (led_level),
        .timer_sel   (timer_sel),
        .remaining_s (remaining_s)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic check(input string sig, input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch at %0t ns: %s expected %0d, got %0d",
                     $time, sig, expected, actual);
            fail_count++;
            case_errs++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;   // inputs move just after the edge
    endtask

    function automatic int tap_ticks();
        return LONG_MS / 8 + ($unsigned($random(seed)) % (LONG_MS / 8 + 1));
    endfunction

    function automatic int timer_minutes(input int sel);
        case (sel)
            1: return 1;
            2: return 3;
            3: return 5;
            default: return 0;
        endcase
    endfunction

    task automatic press_button(input int b, input int hold_ticks);
        btn[b] = 1'b1;
        wait_cycles(hold_ticks * TICK_DIV);
        btn[b] = 1'b0;
    endtask

    task automatic wait_expiry();
        int limit;
        int waited;
        int last_s;
        limit  = 2 * 60 * SEC_MS * TICK_DIV;   // two minutes of ticks
        waited = 0;
        last_s = remaining_s;
        while ((fan_level != '0 || timer_sel != TMR_OFF) && waited < limit) begin
            wait_cycles(1);
            waited++;
            if (remaining_s > last_s) begin
                $display("remaining_s rose from %0d to %0d at %0t ns",
                         last_s, remaining_s, $time);
                fail_count++;
                case_errs++;
            end
            last_s = remaining_s;
        end
        if (waited >= limit) begin
            $display("Off-timer did not stop the fan within two minutes of ticks");
            fail_count++;
            case_errs++;
        end
    endtask

    task automatic run_gesture(input string code, input int b);
        if (code == "E") begin
            wait_expiry();
        end else begin
            if (code == "L") begin
                press_button(b, 2 * LONG_MS);
            end else begin
                press_button(b, tap_ticks());
                if (code == "D") begin
                    wait_cycles(GAP_MS / 4 * TICK_DIV);
                    press_button(b, tap_ticks());
                end
            end
            wait_cycles((GAP_MS + LONG_MS) * TICK_DIV);   // classifier settles
        end
    endtask

    task automatic load_cases();
        int    fd;
        string line;
        string name;
        string code;
        int    b, f, l, t;
        fd = $fopen("bench/fan_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%s %d %s %d %d %d", name, b, code, f, l, t) == 6) begin
                    case_name.push_back(name);
                    case_btn.push_back(b);
                    case_code.push_back(code);
                    exp_fan.push_back(f);
                    exp_led.push_back(l);
                    exp_tmr.push_back(t);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Watchdog ran out after %0d ns, the tests did not finish", limit_ns);
        $display("Something failed");
        $finish;
    end

    initial begin
        int     high;
        int     passed;
        int     asserts_before;
        longint budget;
        passed  = 0;
        budget  = 3_000_000;   // spare allowance for reset
        btn     = 3'b000;
        reset_p = 1'b1;
        load_cases();
        foreach (case_code[i]) begin
            if (case_code[i] == "E") begin
                budget += longint'(2 * 60 * SEC_MS) * TICK_DIV * CLK_NS;
            end else begin
                budget += 3_000_000;   // 3 ms per gesture
            end
        end
        limit_ns = budget;
        repeat (10) @(posedge clk);
        #1 reset_p = 1'b0;
        wait_cycles(2);
        check("fan_level", 0, fan_level);
        check("led_level", 0, led_level);
        check("timer_sel", TMR_OFF, timer_sel);
        check("remaining_s", 0, remaining_s);
        check("fan_pwm", 0, fan_pwm);
        check("led_pwm", 0, led_pwm);
        if (case_name.size() == 0) begin
            $display("No test cases could be read from bench/fan_cases.txt");
            fail_count++;
        end
        foreach (case_name[i]) begin
            case_errs = 0;
            asserts_before = dut_i.checker_i.error_count;
            run_gesture(case_code[i], case_btn[i]);
            check("fan_level", exp_fan[i], fan_level);
            check("led_level", exp_led[i], led_level);
            check("timer_sel", exp_tmr[i], timer_sel);
            if (case_code[i] == "T" || case_code[i] == "E") begin
                check("remaining_s", timer_minutes(exp_tmr[i]) * MIN_S, remaining_s);
            end
            high = 0;
            repeat (1 << FAN_PWM_W) begin
                wait_cycles(1);
                high += fan_pwm;
            end
            check("fan_pwm high cycles", FAN_DUTY[exp_fan[i]], high);
            high = 0;
            repeat (1 << LED_PWM_W) begin
                wait_cycles(1);
                high += led_pwm;
            end
            check("led_pwm high cycles", LED_DUTY[exp_led[i]], high);
            case_errs += dut_i.checker_i.error_count - asserts_before;
            passed += (case_errs == 0);
            $display("%-16s %s", case_name[i], (case_errs == 0) ? "pass" : "fail");
        end
        fail_count += dut_i.checker_i.error_count;
        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 case_name.size(), passed, case_name.size() - passed, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- bench/fan_tb_checker.sv
`timescale 1ns/1ns

module fan_tb_checker import fan_pkg::*; (
    input logic       clk,
    input logic       reset_p,
    input fan_level_t fan_level,
    input led_level_t led_level,
    input logic       led_pwm,
    input timer_sel_t timer_sel
);

    int error_count = 0;

    // one step either way, or straight to idle
    fan_step: assert property (@(posedge clk) disable iff (reset_p)
        (fan_level != $past(fan_level) && fan_level != '0) |->
            (fan_level == fan_level_t'($past(fan_level) + 1'b1) ||
             fan_level == fan_level_t'($past(fan_level) - 1'b1)))
        else begin
            $error("fan_level jumped from %0d to %0d", $past(fan_level), fan_level);
            error_count++;
        end

    // idle fan drops the timer
    timer_idle: assert property (@(posedge clk) disable iff (reset_p)
        (fan_level == '0 && $past(fan_level) == '0) |-> timer_sel == TMR_OFF)
        else begin
            $error("timer_sel is %0d while the fan is idle", timer_sel);
            error_count++;
        end

    // pwm is registered, so allow a cycle
    led_dark: assert property (@(posedge clk) disable iff (reset_p)
        (led_level == '0 && $past(led_level) == '0) |-> !led_pwm)
        else begin
            $error("led_pwm high with led_level 0");
            error_count++;
        end

endmodule

bind fan_top fan_tb_checker checker_i (
    .clk       (clk),
    .reset_p   (reset_p),
    .fan_level (fan_level),
    .led_level (led_level),
    .led_pwm   (led_pwm),
    .timer_sel (timer_sel)
);

//--- flist.f
hdl/button_pkg.sv
hdl/fan_pkg.sv
hdl/ms_tick_gen.sv
hdl/press_classifier.sv
hdl/pwm_gen.sv
hdl/fan_speed_ctrl.sv
hdl/led_dimmer.sv
hdl/off_timer.sv
hdl/fan_top.sv
bench/fan_tb_checker.sv
bench/fan_tb.sv

//--- hdl/button_pkg.sv
package button_pkg;

    // what the classifier reports, one cycle per gesture
    typedef enum logic [1:0] {
        PRESS_NONE,
        PRESS_SINGLE,
        PRESS_DOUBLE,
        PRESS_LONG
    } press_kind_t;

    // held this many ms ticks means a long press
    localparam int LONG_MS = 700;

    // window after release for the second tap
    localparam int GAP_MS = 200;

    // ms tick counter, wide enough for LONG_MS
    typedef logic [10:0] ms_count_t;

endpackage

//--- hdl/fan_pkg.sv
package fan_pkg;

    // clk cycles per ms tick at 125 MHz
    localparam int TICK_DIV_DEFAULT = 125000;

    typedef logic [2:0] fan_level_t;   // 0 idle, 1..7 speeds

    localparam int FAN_PWM_W = 12;     // 4096 cycle period

    typedef logic [11:0] fan_duty_t;

    localparam fan_duty_t FAN_DUTY [0:7] = '{
        12'd0, 12'd1023, 12'd1535, 12'd2047,
        12'd2559, 12'd3071, 12'd3583, 12'd4095
    };

    typedef logic [1:0] led_level_t;

    localparam int LED_PWM_W = 6;      // 64 cycle period

    typedef logic [6:0] led_duty_t;    // 64 is full on

    localparam led_duty_t LED_DUTY [0:3] = '{7'd0, 7'd13, 7'd38, 7'd64};

    typedef enum logic [1:0] {
        TMR_OFF,
        TMR_1,
        TMR_3,
        TMR_5
    } timer_sel_t;

    localparam int SEC_MS = 1000;      // ticks per second
    localparam int MIN_S  = 60;

    typedef logic [8:0] secs_t;        // up to 300 s

endpackage

//--- hdl/fan_speed_ctrl.sv
`timescale 1ns/1ns

module fan_speed_ctrl import button_pkg::*, fan_pkg::*; (
    input  logic        clk,
    input  logic        reset_p,
    input  press_kind_t press,
    input  logic        timer_expired,
    output fan_level_t  fan_level,
    output logic        fan_running,
    output logic        fan_pwm
);

    fan_duty_t fan_duty;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            fan_level <= '0;
        end else begin
            if (timer_expired || press == PRESS_LONG) begin
                fan_level <= '0;   // stop
            end else if (press == PRESS_SINGLE) begin
                fan_level <= fan_level + fan_level_t'(1);   // 7 wraps to idle
            end else if (press == PRESS_DOUBLE) begin
                fan_level <= fan_level - fan_level_t'(1);   // idle wraps to 7
            end
        end
    end

    assign fan_running = (fan_level != '0);
    assign fan_duty    = FAN_DUTY[fan_level];

    pwm_gen #(
        .W (FAN_PWM_W)
    ) fan_pwm_i (
        .clk     (clk),
        .reset_p (reset_p),
        .duty    ({1'b0, fan_duty}),
        .pwm     (fan_pwm)
    );

endmodule

//--- hdl/fan_top.sv
`timescale 1ns/1ns

module fan_top import button_pkg::*, fan_pkg::*; #(
    parameter int TICK_DIV = TICK_DIV_DEFAULT
) (
    input  logic       clk,
    input  logic       reset_p,
    input  logic [2:0] btn,
    output logic       fan_pwm,
    output logic       led_pwm,
    output fan_level_t fan_level,
    output led_level_t led_level,
    output timer_sel_t timer_sel,
    output secs_t      remaining_s
);

    logic        ms_tick;
    logic        fan_running;
    logic        timer_expired;
    press_kind_t fan_press;
    press_kind_t led_press;

    ms_tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) tick_i (
        .clk     (clk),
        .reset_p (reset_p),
        .ms_tick (ms_tick)
    );

    press_classifier fan_btn_i (
        .clk     (clk),
        .reset_p (reset_p),
        .btn     (btn[0]),
        .ms_tick (ms_tick),
        .press   (fan_press)
    );

    press_classifier led_btn_i (
        .clk     (clk),
        .reset_p (reset_p),
        .btn     (btn[1]),
        .ms_tick (ms_tick),
        .press   (led_press)
    );

    fan_speed_ctrl fan_i (
        .clk           (clk),
        .reset_p       (reset_p),
        .press         (fan_press),
        .timer_expired (timer_expired),
        .fan_level     (fan_level),
        .fan_running   (fan_running),
        .fan_pwm       (fan_pwm)
    );

    led_dimmer led_i (
        .clk       (clk),
        .reset_p   (reset_p),
        .press     (led_press),
        .led_level (led_level),
        .led_pwm   (led_pwm)
    );

    off_timer timer_i (
        .clk           (clk),
        .reset_p       (reset_p),
        .btn           (btn[2]),    // raw, synchronized inside
        .ms_tick       (ms_tick),
        .fan_running   (fan_running),
        .timer_sel     (timer_sel),
        .remaining_s   (remaining_s),
        .timer_expired (timer_expired)
    );

endmodule

//--- hdl/led_dimmer.sv
`timescale 1ns/1ns

module led_dimmer import button_pkg::*, fan_pkg::*; (
    input  logic        clk,
    input  logic        reset_p,
    input  press_kind_t press,
    output led_level_t  led_level,
    output logic        led_pwm
);

    led_duty_t led_duty;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            led_level <= '0;
        end else begin
            if (press == PRESS_LONG) begin
                led_level <= '0;
            end else if (press == PRESS_SINGLE) begin
                led_level <= led_level + led_level_t'(1);   // 3 wraps to off
            end
            // double tap does nothing here
        end
    end

    assign led_duty = LED_DUTY[led_level];

    pwm_gen #(
        .W (LED_PWM_W)
    ) led_pwm_i (
        .clk     (clk),
        .reset_p (reset_p),
        .duty    (led_duty),
        .pwm     (led_pwm)
    );

endmodule

//--- hdl/ms_tick_gen.sv
`timescale 1ns/1ns

module ms_tick_gen #(
    parameter int TICK_DIV = 125000
) (
    input  logic clk,
    input  logic reset_p,
    output logic ms_tick
);

    logic [$clog2(TICK_DIV)-1:0] div_cnt;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt <= '0;
            ms_tick <= 1'b0;
        end else begin
            if (div_cnt == ($clog2(TICK_DIV))'(TICK_DIV - 1)) begin
                div_cnt <= '0;
                ms_tick <= 1'b1;   // one pulse per wrap
            end else begin
                div_cnt <= div_cnt + 1'b1;
                ms_tick <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/off_timer.sv
`timescale 1ns/1ns

module off_timer import button_pkg::*, fan_pkg::*; (
    input  logic       clk,
    input  logic       reset_p,
    input  logic       btn,
    input  logic       ms_tick,
    input  logic       fan_running,
    output timer_sel_t timer_sel,
    output secs_t      remaining_s,
    output logic       timer_expired
);

    logic [1:0] sync_q;
    logic       btn_q;
    logic       rise;
    logic       fall;
    ms_count_t  sec_div;    // ms ticks within the current second
    secs_t      load_s;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sync_q <= 2'b00;
            btn_q  <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], btn};
            btn_q  <= sync_q[1];
        end
    end

    assign rise = sync_q[1] & ~btn_q;
    assign fall = ~sync_q[1] & btn_q;

    always_comb begin
        case (timer_sel)
            TMR_1:   load_s = secs_t'(1 * MIN_S);
            TMR_3:   load_s = secs_t'(3 * MIN_S);
            TMR_5:   load_s = secs_t'(5 * MIN_S);
            default: load_s = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            timer_sel     <= TMR_OFF;
            remaining_s   <= '0;
            sec_div       <= '0;
            timer_expired <= 1'b0;
        end else begin
            timer_expired <= 1'b0;
            if (!fan_running) begin
                timer_sel   <= TMR_OFF;   // fan stopped, drop the timer
                remaining_s <= '0;
            end else if (rise) begin
                case (timer_sel)
                    TMR_OFF: timer_sel <= TMR_1;
                    TMR_1:   timer_sel <= TMR_3;
                    TMR_3:   timer_sel <= TMR_5;
                    default: timer_sel <= TMR_OFF;
                endcase
            end else if (fall) begin
                remaining_s <= load_s;   // countdown starts on release
                sec_div     <= '0;
            end else if (timer_sel != TMR_OFF && remaining_s != '0 && ms_tick) begin
                if (sec_div == ms_count_t'(SEC_MS - 1)) begin
                    sec_div     <= '0;
                    remaining_s <= remaining_s - secs_t'(1);
                    if (remaining_s == secs_t'(1)) begin
                        timer_expired <= 1'b1;
                        timer_sel     <= TMR_OFF;
                    end
                end else begin
                    sec_div <= sec_div + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/press_classifier.sv
`timescale 1ns/1ns

module press_classifier import button_pkg::*; (
    input  logic        clk,
    input  logic        reset_p,
    input  logic        btn,
    input  logic        ms_tick,
    output press_kind_t press
);

    typedef enum logic [1:0] {
        ST_WAIT,     // idle, waiting for a press
        ST_HELD,     // first press down
        ST_GAP,      // released, looking for a second tap
        ST_SECOND    // double reported, waiting for release
    } state_t;

    state_t     state;
    logic [1:0] sync_q;
    logic       btn_q;
    logic       rise;
    logic       fall;
    ms_count_t  ms_cnt;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sync_q <= 2'b00;
            btn_q  <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], btn};
            btn_q  <= sync_q[1];
        end
    end

    assign rise = sync_q[1] & ~btn_q;
    assign fall = ~sync_q[1] & btn_q;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state  <= ST_WAIT;
            ms_cnt <= '0;
            press  <= PRESS_NONE;
        end else begin
            press <= PRESS_NONE;   // pulse by default
            case (state)
                ST_WAIT: begin
                    if (rise) begin
                        ms_cnt <= '0;
                        state  <= ST_HELD;
                    end
                end

                ST_HELD: begin
                    if (fall) begin
                        ms_cnt <= '0;
                        state  <= ST_GAP;
                    end else if (ms_tick) begin
                        if (ms_cnt == ms_count_t'(LONG_MS - 1)) begin
                            press <= PRESS_LONG;
                            state <= ST_WAIT;   // the release is ignored there
                        end else begin
                            ms_cnt <= ms_cnt + 1'b1;
                        end
                    end
                end

                ST_GAP: begin
                    if (rise) begin
                        press <= PRESS_DOUBLE;
                        state <= ST_SECOND;
                    end else if (ms_tick) begin
                        if (ms_cnt == ms_count_t'(GAP_MS - 1)) begin
                            press <= PRESS_SINGLE;
                            state <= ST_WAIT;
                        end else begin
                            ms_cnt <= ms_cnt + 1'b1;
                        end
                    end
                end

                ST_SECOND: begin
                    if (fall) begin
                        state <= ST_WAIT;
                    end
                end

                default: begin
                    state <= ST_WAIT;
                end
            endcase
        end
    end

endmodule

//--- hdl/pwm_gen.sv
`timescale 1ns/1ns

module pwm_gen #(
    parameter int W = 12
) (
    input  logic         clk,
    input  logic         reset_p,
    input  logic [W:0]   duty,     // one bit wider so full on fits
    output logic         pwm
);

    logic [W-1:0] pwm_cnt;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            pwm_cnt <= '0;
            pwm     <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;   // free running, wraps
            pwm     <= ({1'b0, pwm_cnt} < duty);
        end
    end

endmodule
